// File: rtl/cache_pkg.sv
package cache_pkg;

	// width of every data and address word
	localparam int WORD_WIDTH = 32;

	// associativity of the data cache
	localparam int WAYS = 4;

	// one full data or address word
	typedef logic [WORD_WIDTH-1:0] word_t;

	// selects one way inside a set
	typedef logic [$clog2(WAYS)-1:0] way_idx_t;

	// lru age per way
	// 0 is the oldest way, WAYS-1 the most recent one
	typedef logic [$clog2(WAYS)-1:0] age_t;

endpackage

// File: rtl/way_store.sv
module way_store #(
	parameter int SET_BITS = 4,
	parameter type payload_t = cache_pkg::word_t
) (
	input logic clk_i,
	input logic [SET_BITS-1:0] set_i,
	input cache_pkg::way_idx_t way_i,
	input logic we_i,
	input payload_t wdata_i,
	output payload_t rdata_o [cache_pkg::WAYS]
);
	import cache_pkg::*;

	localparam int SETS = 2 ** SET_BITS;

	// one entry per set and way
	payload_t entry_q [SETS][WAYS];

	// single way of one set per strobe
	always_ff @(posedge clk_i) begin
		if (we_i) begin
			entry_q[set_i][way_i] <= wdata_i;
		end
	end

	// whole set visible at once for the tag compare
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			rdata_o[w] = entry_q[set_i][w];
		end
	end

endmodule

// File: rtl/lru_ages.sv
module lru_ages #(
	parameter int SET_BITS = 4
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic [SET_BITS-1:0] set_i,
	input logic touch_i,
	input cache_pkg::way_idx_t touch_way_i,
	output cache_pkg::way_idx_t victim_o
);
	import cache_pkg::*;

	localparam int SETS = 2 ** SET_BITS;
	// age given to the way just used
	localparam age_t AGE_MRU = age_t'(WAYS - 1);

	age_t ages_q [SETS][WAYS];
	// ages of the addressed set
	age_t ages_set [WAYS];
	// age of the touched way before the update
	age_t touched_age;

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			ages_set[w] = ages_q[set_i][w];
		end
	end

	assign touched_age = ages_set[touch_way_i];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			// start with age equal to way index
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					ages_q[s][w] <= age_t'(w);
				end
			end
		end else if (touch_i) begin
			for (int w = 0; w < WAYS; w++) begin
				if (way_idx_t'(w) == touch_way_i) begin
					// touched way becomes most recent
					ages_q[set_i][w] <= AGE_MRU;
				end else if (ages_set[w] > touched_age) begin
					// only the younger ones move down
					ages_q[set_i][w] <= ages_set[w] - 1'b1;
				end
			end
		end
	end

	// ages in a set are a permutation, so exactly one way is at 0
	always_comb begin
		victim_o = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (ages_set[w] == '0) begin
				victim_o = way_idx_t'(w);
			end
		end
	end

endmodule

// File: rtl/cache_controller.sv
module cache_controller #(
	parameter int SET_BITS = 4,
	localparam int TAG_BITS = cache_pkg::WORD_WIDTH - SET_BITS - 2
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic req_i,
	input logic write_enable_i,
	input cache_pkg::word_t address_i,
	input cache_pkg::word_t write_data_i,
	output logic done_o,
	output logic hit_o,
	output logic busy_o,
	output cache_pkg::word_t read_data_o,
	input logic [TAG_BITS-1:0] set_tags_i [cache_pkg::WAYS],
	input cache_pkg::word_t set_data_i [cache_pkg::WAYS],
	input cache_pkg::way_idx_t victim_i,
	output logic [SET_BITS-1:0] set_o,
	output cache_pkg::way_idx_t store_way_o,
	output logic store_we_o,
	output logic [TAG_BITS-1:0] store_tag_o,
	output cache_pkg::word_t store_data_o,
	output logic touch_o,
	output cache_pkg::way_idx_t touch_way_o,
	output logic mem_read_o,
	output logic mem_write_o,
	output cache_pkg::word_t mem_address_o,
	output cache_pkg::word_t mem_write_data_o,
	input logic mem_ready_i,
	input cache_pkg::word_t mem_read_data_i
);
	import cache_pkg::*;

	localparam int SETS = 2 ** SET_BITS;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_READ,
		ST_WAIT_WRITE
	} state_t;

	state_t state_q;
	logic valid_q [SETS][WAYS];

	// request captured when accepted
	word_t addr_q;
	word_t data_q;
	logic hit_pend_q;

	logic done_q;
	logic hit_q;
	word_t rdata_q;
	logic mem_read_q;
	logic mem_write_q;

	word_t cur_addr;
	logic [TAG_BITS-1:0] cur_tag;
	logic accept;
	logic fill;
	logic hit;
	way_idx_t hit_way;

	// live address while idle, held address while waiting on memory
	assign cur_addr = (state_q == ST_IDLE) ? address_i : addr_q;
	assign set_o = cur_addr[SET_BITS+1:2];
	assign cur_tag = cur_addr[WORD_WIDTH-1:SET_BITS+2];

	// requests while busy are dropped
	assign accept = req_i && (state_q == ST_IDLE);
	// read miss data coming back
	assign fill = (state_q == ST_WAIT_READ) && mem_ready_i;

	// tag compare over all ways of the set
	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid_q[set_o][w] && (set_tags_i[w] == cur_tag)) begin
				hit = 1'b1;
				hit_way = way_idx_t'(w);
			end
		end
	end

	// hit way on a store hit, victim on store miss and on fill
	assign store_way_o = (accept && hit) ? hit_way : victim_i;
	// write allocate, so every store writes the arrays
	assign store_we_o = (accept && write_enable_i) || fill;
	assign store_tag_o = cur_tag;
	assign store_data_o = fill ? mem_read_data_i : write_data_i;

	// a read miss touches only when the line arrives
	assign touch_o = (accept && (hit || write_enable_i)) || fill;
	assign touch_way_o = store_way_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					valid_q[s][w] <= 1'b0;
				end
			end
		end else if (store_we_o) begin
			valid_q[set_o][store_way_o] <= 1'b1;
		end
	end

	// request FSM
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			done_q <= 1'b0;
			hit_q <= 1'b0;
			mem_read_q <= 1'b0;
			mem_write_q <= 1'b0;
		end else begin
			// strobes last one cycle
			done_q <= 1'b0;
			mem_read_q <= 1'b0;
			mem_write_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						if (write_enable_i) begin
							// write through on hit and miss alike
							state_q <= ST_WAIT_WRITE;
							mem_write_q <= 1'b1;
						end else if (hit) begin
							done_q <= 1'b1;
							hit_q <= 1'b1;
						end else begin
							state_q <= ST_WAIT_READ;
							mem_read_q <= 1'b1;
						end
					end
				end
				ST_WAIT_READ: begin
					if (mem_ready_i) begin
						state_q <= ST_IDLE;
						done_q <= 1'b1;
						hit_q <= 1'b0;
					end
				end
				ST_WAIT_WRITE: begin
					if (mem_ready_i) begin
						state_q <= ST_IDLE;
						done_q <= 1'b1;
						hit_q <= hit_pend_q;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// request payload and returned word
	always_ff @(posedge clk_i) begin
		if (accept) begin
			addr_q <= address_i;
			data_q <= write_data_i;
			hit_pend_q <= hit;
			if (!write_enable_i && hit) begin
				rdata_q <= set_data_i[hit_way];
			end
		end
		if (fill) begin
			rdata_q <= mem_read_data_i;
		end
		// stores return the stored word
		if ((state_q == ST_WAIT_WRITE) && mem_ready_i) begin
			rdata_q <= data_q;
		end
	end

	assign done_o = done_q;
	assign hit_o = hit_q;
	assign read_data_o = rdata_q;
	assign busy_o = (state_q != ST_IDLE);

	assign mem_read_o = mem_read_q;
	assign mem_write_o = mem_write_q;
	assign mem_address_o = addr_q;
	assign mem_write_data_o = data_q;

endmodule

// File: rtl/main_memory.sv
module main_memory #(
	parameter int MEM_ADDR_BITS = 10,
	parameter int MEM_LATENCY = 3
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic read_i,
	input logic write_i,
	input cache_pkg::word_t address_i,
	input cache_pkg::word_t write_data_i,
	output logic ready_o,
	output cache_pkg::word_t read_data_o
);
	import cache_pkg::*;

	localparam int DEPTH = 2 ** MEM_ADDR_BITS;
	localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

	word_t mem_q [DEPTH];
	// word index, byte offset dropped
	logic [MEM_ADDR_BITS-1:0] index;
	// cycles left until ready
	logic [CNT_BITS-1:0] count_q;
	logic ready_q;
	word_t rdata_q;

	assign index = address_i[MEM_ADDR_BITS+1:2];

	// write lands at the strobe edge
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem_q[i] <= '0;
			end
		end else if (write_i) begin
			mem_q[index] <= write_data_i;
		end
	end

	// one ready pulse MEM_LATENCY cycles after any strobe
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q <= '0;
			ready_q <= 1'b0;
		end else if (read_i || write_i) begin
			count_q <= CNT_BITS'(MEM_LATENCY - 1);
			ready_q <= (MEM_LATENCY == 1);
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
			ready_q <= (count_q == CNT_BITS'(1));
		end else begin
			ready_q <= 1'b0;
		end
	end

	// read word sampled at the strobe, shown with ready
	always_ff @(posedge clk_i) begin
		if (read_i) begin
			rdata_q <= mem_q[index];
		end
	end

	assign ready_o = ready_q;
	assign read_data_o = rdata_q;

endmodule

// File: rtl/cache_top.sv
module cache_top #(
	parameter int SET_BITS = 4,
	parameter int MEM_ADDR_BITS = 10,
	parameter int MEM_LATENCY = 3
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic req_i,
	input logic write_enable_i,
	input cache_pkg::word_t address_i,
	input cache_pkg::word_t write_data_i,
	output logic done_o,
	output logic hit_o,
	output logic busy_o,
	output cache_pkg::word_t read_data_o
);
	import cache_pkg::*;

	localparam int TAG_BITS = WORD_WIDTH - SET_BITS - 2;

	// controller to way stores
	logic [SET_BITS-1:0] set;
	way_idx_t store_way;
	logic store_we;
	logic [TAG_BITS-1:0] store_tag;
	word_t store_data;
	logic [TAG_BITS-1:0] set_tags [WAYS];
	word_t set_data [WAYS];

	// controller to ages
	logic touch;
	way_idx_t touch_way;
	way_idx_t victim;

	// controller to memory
	logic mem_read;
	logic mem_write;
	logic mem_ready;
	word_t mem_address;
	word_t mem_write_data;
	word_t mem_read_data;

	cache_controller #(
		.SET_BITS(SET_BITS)
	) controller0 (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.req_i(req_i),
		.write_enable_i(write_enable_i),
		.address_i(address_i),
		.write_data_i(write_data_i),
		.done_o(done_o),
		.hit_o(hit_o),
		.busy_o(busy_o),
		.read_data_o(read_data_o),
		.set_tags_i(set_tags),
		.set_data_i(set_data),
		.victim_i(victim),
		.set_o(set),
		.store_way_o(store_way),
		.store_we_o(store_we),
		.store_tag_o(store_tag),
		.store_data_o(store_data),
		.touch_o(touch),
		.touch_way_o(touch_way),
		.mem_read_o(mem_read),
		.mem_write_o(mem_write),
		.mem_address_o(mem_address),
		.mem_write_data_o(mem_write_data),
		.mem_ready_i(mem_ready),
		.mem_read_data_i(mem_read_data)
	);

	// tags and data share set, way and strobe
	way_store #(
		.SET_BITS(SET_BITS),
		.payload_t(logic [TAG_BITS-1:0])
	) tag_store (
		.clk_i(clk_i),
		.set_i(set),
		.way_i(store_way),
		.we_i(store_we),
		.wdata_i(store_tag),
		.rdata_o(set_tags)
	);

	way_store #(
		.SET_BITS(SET_BITS),
		.payload_t(word_t)
	) data_store (
		.clk_i(clk_i),
		.set_i(set),
		.way_i(store_way),
		.we_i(store_we),
		.wdata_i(store_data),
		.rdata_o(set_data)
	);

	lru_ages #(
		.SET_BITS(SET_BITS)
	) ages0 (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.set_i(set),
		.touch_i(touch),
		.touch_way_i(touch_way),
		.victim_o(victim)
	);

	main_memory #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_LATENCY(MEM_LATENCY)
	) memory0 (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.read_i(mem_read),
		.write_i(mem_write),
		.address_i(mem_address),
		.write_data_i(mem_write_data),
		.ready_o(mem_ready),
		.read_data_o(mem_read_data)
	);

endmodule

// File: testbench/tb_clock.sv
module tb_clock #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_o,
	output logic rst_n_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// first rising edge at half a period
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// reset covers two rising edges, released on a falling edge
	initial begin
		rst_n_o = 1'b0;
		#(RESET_CYCLES * PERIOD_NS);
		rst_n_o = 1'b1;
	end

endmodule

// File: testbench/cache_tb.sv
module cache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cache_pkg::*;

	localparam int SET_BITS = 4;
	localparam int MEM_ADDR_BITS = 10;
	localparam int MEM_LATENCY = 3;
	localparam int SETS = 2 ** SET_BITS;
	// cycles without done on the memory path
	localparam int MISS_GAP = MEM_LATENCY + 1;
	localparam int RANDOM_REQUESTS = 300;
	localparam int TIMEOUT_CYCLES = 400 * (MEM_LATENCY + 4);

	logic clk;
	logic rst_n;
	logic req;
	logic write_enable;
	word_t address;
	word_t write_data;
	logic done;
	logic hit;
	logic busy;
	word_t read_data;

	// reference model of memory, tags and ages
	word_t model_mem [2 ** MEM_ADDR_BITS];
	word_t model_tag [SETS][WAYS];
	logic model_valid [SETS][WAYS];
	age_t model_age [SETS][WAYS];
	// expected result of the request in flight
	logic exp_hit;
	word_t exp_data;
	int unsigned cycle_count = 0;

	tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(2)) clock0 (.clk_o(clk), .rst_n_o(rst_n));

	cache_top #(
		.SET_BITS(SET_BITS),
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_LATENCY(MEM_LATENCY)
	) dut0 (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.req_i(req),
		.write_enable_i(write_enable),
		.address_i(address),
		.write_data_i(write_data),
		.done_o(done),
		.hit_o(hit),
		.busy_o(busy),
		.read_data_o(read_data)
	);

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	function automatic word_t line_address(input int tag, input int set_idx);
		return (word_t'(tag) << (SET_BITS + 2)) | (word_t'(set_idx) << 2);
	endfunction

	// applies one request to the model and sets the expected result
	task automatic predict_result(input logic we, input word_t addr, input word_t data);
		int set_idx;
		int mem_idx;
		int way;
		word_t tag;
		age_t old_age;
		set_idx = int'(addr[SET_BITS+1:2]);
		mem_idx = int'(addr[MEM_ADDR_BITS+1:2]);
		tag = addr >> (SET_BITS + 2);
		exp_hit = 1'b0;
		way = 0;
		for (int w = 0; w < WAYS; w++) begin
			if (model_valid[set_idx][w] && (model_tag[set_idx][w] == tag)) begin
				exp_hit = 1'b1;
				way = w;
			end
		end
		// miss allocates the way of age 0
		if (!exp_hit) begin
			for (int w = 0; w < WAYS; w++) begin
				if (model_age[set_idx][w] == 0) way = w;
			end
		end
		if (we) begin
			model_mem[mem_idx] = data;
		end
		// write-through keeps the cached word equal to memory
		exp_data = model_mem[mem_idx];
		model_valid[set_idx][way] = 1'b1;
		model_tag[set_idx][way] = tag;
		old_age = model_age[set_idx][way];
		for (int w = 0; w < WAYS; w++) begin
			if (model_age[set_idx][w] > old_age) model_age[set_idx][w]--;
		end
		model_age[set_idx][way] = 2'd3;
	endtask

	task automatic issue_request(input logic we, input word_t addr, input word_t data);
		@(negedge clk);
		while (busy) @(negedge clk);
		predict_result(we, addr, data);
		req = 1'b1;
		write_enable = we;
		address = addr;
		write_data = data;
		@(negedge clk);
		req = 1'b0;
		while (!done) @(negedge clk);
	endtask

	// result compare on every done pulse
	result_check: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> ((hit == exp_hit) && (read_data == exp_data)))
		else stop_with_error($sformatf("[ERROR] %0t: hit %b data %h, expected hit %b data %h",
			$time, hit, read_data, exp_hit, exp_data));

	// read hit answers in the next cycle
	hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(req && !busy && !write_enable && exp_hit) |=> done)
		else stop_with_error($sformatf("[ERROR] %0t: read hit without done one cycle later",
			$time));

	// stores and read misses wait for the memory
	miss_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(req && !busy && (write_enable || !exp_hit)) |=> !done [*MISS_GAP] ##1 done)
		else stop_with_error($sformatf("[ERROR] %0t: done not %0d cycles after request",
			$time, MEM_LATENCY + 2));

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			stop_with_error($sformatf("timeout: run still going after %0d cycles", cycle_count));
		end
	end

	initial begin
		logic we;
		word_t addr;
		req = 1'b0;
		write_enable = 1'b0;
		address = '0;
		write_data = '0;
		void'($urandom(32'h00fc0ca9));
		// model state after reset
		foreach (model_mem[i]) model_mem[i] = '0;
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
				model_age[s][w] = age_t'(w);
			end
		end
		@(posedge rst_n);
		@(negedge clk);
		idle_after_reset: assert (!done && !busy)
			else stop_with_error($sformatf("[ERROR] %0t: done or busy high after reset", $time));
		// cold read misses and returns zero
		issue_request(1'b0, line_address(1, 0), '0);
		issue_request(1'b0, 32'h0000_0a5c, '0);
		// store then read back as a hit
		issue_request(1'b1, line_address(4, 1), 32'hcafe_0104);
		issue_request(1'b0, line_address(4, 1), '0);
		// five tags in set 3, ways fill 0 to 3
		for (int t = 1; t <= 4; t++) begin
			issue_request(1'b1, line_address(t, 3), 32'h3000_0000 + t);
		end
		// refresh 1, 3 and 2 so tag 4 is oldest
		issue_request(1'b0, line_address(1, 3), '0);
		issue_request(1'b0, line_address(3, 3), '0);
		issue_request(1'b0, line_address(2, 3), '0);
		issue_request(1'b0, line_address(5, 3), '0);
		issue_request(1'b0, line_address(1, 3), '0);
		issue_request(1'b0, line_address(2, 3), '0);
		issue_request(1'b0, line_address(3, 3), '0);
		issue_request(1'b0, line_address(5, 3), '0);
		// evicted store comes back from memory
		issue_request(1'b0, line_address(4, 3), '0);
		// random mix over sets 0..3, eight tags each
		for (int n = 0; n < RANDOM_REQUESTS; n++) begin
			we = (($urandom % 3) == 0);
			addr = line_address($urandom % 8, $urandom % 4);
			issue_request(we, addr, $urandom);
		end
		// let the last done reach its check
		repeat (2) @(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: list.f
rtl/cache_pkg.sv
rtl/way_store.sv
rtl/lru_ages.sv
rtl/cache_controller.sv
rtl/main_memory.sv
rtl/cache_top.sv
testbench/tb_clock.sv
testbench/cache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - rtl/cache_pkg.sv
  - rtl/way_store.sv
  - rtl/lru_ages.sv
  - rtl/cache_controller.sv
  - rtl/main_memory.sv
  - rtl/cache_top.sv
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/cache_tb.sv
